//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f rv32i_core.f \
	--top-module tb_rv32i_core -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "test passed" \
	|| exit 1

//--- rv32i_core.f
source/rv32i_types.sv
source/control_rom.sv
source/core_fsm.sv
source/pc_unit.sv
source/regfile.sv
source/exec_unit.sv
source/data_ram.sv
source/rv32i_core.sv
verif/clk_gen.sv
verif/rv32i_core_sva.sv
verif/tb_rv32i_core.sv

//--- source/control_rom.sv
`default_nettype none

module control_rom (
	input wire rv32i_types::rv32i_opcode opcode,
	input wire logic [2:0] funct3,
	input wire logic [6:0] funct7,
	output rv32i_types::rv32i_control_word ctrl
);
	import rv32i_types::*;

	always_comb begin
		// defaults, most opcodes only touch a few fields
		ctrl.opcode = opcode;
		ctrl.aluop = alu_ops'(funct3);
		ctrl.cmpop = branch_funct3_t'(funct3);
		ctrl.load_regfile = 1'b0;
		ctrl.regfilemux_sel = 3'd0;
		ctrl.pcmux_sel = 1'b0;
		ctrl.alumux1_sel = 1'b0;
		ctrl.alumux2_sel = 3'd0;
		ctrl.cmpmux_sel = 1'b0;
		ctrl.load_type = 2'd0; // word
		ctrl.load_unsigned = 1'b0;
		ctrl.store_type = 2'd0; // word
		ctrl.write = 1'b0;
		ctrl.read_b = 1'b0;

		case (opcode)
			op_lui: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd2;
			end

			op_auipc: begin
				ctrl.load_regfile = 1'b1;
				ctrl.aluop = alu_add;
				ctrl.alumux1_sel = 1'b1; // pc + u_imm
				ctrl.alumux2_sel = 3'd1;
			end

			op_jal: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd4; // link value
				ctrl.pcmux_sel = 1'b1;
				ctrl.alumux1_sel = 1'b1;
				ctrl.alumux2_sel = 3'd5;
				ctrl.aluop = alu_add;
			end

			op_jalr: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd4;
				ctrl.pcmux_sel = 1'b1; // rs1 + i_imm
				ctrl.aluop = alu_add;
			end

			op_br: begin
				ctrl.alumux1_sel = 1'b1; // target is pc + b_imm
				ctrl.alumux2_sel = 3'd2;
				ctrl.aluop = alu_add;
			end

			op_load: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd3;
				ctrl.aluop = alu_add;
				ctrl.read_b = 1'b1;
				case (load_funct3_t'(funct3))
					lb: ctrl.load_type = 2'd1;
					lh: ctrl.load_type = 2'd2;
					lbu: begin
						ctrl.load_type = 2'd1;
						ctrl.load_unsigned = 1'b1;
					end
					lhu: begin
						ctrl.load_type = 2'd2;
						ctrl.load_unsigned = 1'b1;
					end
					default: ; // lw
				endcase
			end

			op_store: begin
				// rd holds immediate bits here so no regfile write
				ctrl.alumux2_sel = 3'd3;
				ctrl.aluop = alu_add;
				ctrl.write = 1'b1;
				case (store_funct3_t'(funct3))
					sb: ctrl.store_type = 2'd1;
					sh: ctrl.store_type = 2'd2;
					default: ; // sw
				endcase
			end

			op_imm: begin
				ctrl.load_regfile = 1'b1;
				case (arith_funct3_t'(funct3))
					slt: begin
						ctrl.cmpop = blt;
						ctrl.regfilemux_sel = 3'd1;
						ctrl.cmpmux_sel = 1'b1;
					end
					sltu: begin
						ctrl.cmpop = bltu;
						ctrl.regfilemux_sel = 3'd1;
						ctrl.cmpmux_sel = 1'b1;
					end
					sr: ctrl.aluop = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
					default: ;
				endcase
			end

			op_reg: begin
				ctrl.load_regfile = 1'b1;
				ctrl.alumux2_sel = 3'd4;
				case (arith_funct3_t'(funct3))
					add: ctrl.aluop = (funct7 == 7'b0100000) ? alu_sub : alu_add;
					slt: begin
						ctrl.cmpop = blt;
						ctrl.regfilemux_sel = 3'd1;
					end
					sltu: begin
						ctrl.cmpop = bltu;
						ctrl.regfilemux_sel = 3'd1;
					end
					sr: ctrl.aluop = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
					default: ; // funct3 already is the alu code
				endcase
			end

			default: ctrl = '0; // csr, fence, system and anything else
		endcase
	end

endmodule

`default_nettype wire

//--- source/core_fsm.sv
`default_nettype none

module core_fsm (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instr_valid,
	input wire rv32i_types::rv32i_instr_u instr,
	input wire rv32i_types::rv32i_control_word ctrl_next,
	input wire logic [31:0] pc,
	input wire logic [31:0] wb_data,
	output logic fetch_req,
	output rv32i_types::rv32i_instr_u ir,
	output rv32i_types::rv32i_control_word ctrl,
	output logic exec_en,
	output logic wb_en,
	output logic retire_valid,
	output rv32i_types::retire_t retire
);
	import rv32i_types::*;

	typedef enum logic [1:0] {s_fetch, s_exec, s_wb} state_t;

	state_t state;
	logic pending; // request is out, word not yet taken
	logic accept;
	rv32i_instr_u ir_q;

	// while fetching the decoder already sees the incoming word,
	// so the control word can be captured on entry to execute
	assign ir = (state == s_fetch) ? instr : ir_q;
	assign accept = (state == s_fetch) && pending && instr_valid;
	assign exec_en = (state == s_exec);
	assign wb_en = (state == s_wb);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_fetch;
			pending <= 1'b0;
			fetch_req <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			fetch_req <= 1'b0;
			retire_valid <= 1'b0;
			case (state)
				s_fetch: begin
					if (!pending) begin // first request after reset
						fetch_req <= 1'b1;
						pending <= 1'b1;
					end else if (instr_valid) begin
						pending <= 1'b0;
						state <= s_exec;
					end
				end
				s_exec: state <= s_wb;
				s_wb: begin
					state <= s_fetch;
					fetch_req <= 1'b1; // next fetch goes out with the retire
					pending <= 1'b1;
					retire_valid <= 1'b1;
				end
				default: state <= s_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ir_q <= instr;
			ctrl <= ctrl_next;
		end
		if (wb_en) begin
			retire.pc <= pc; // pc of the retiring instruction, before update
			retire.rd <= ir_q.r_fmt.rd;
			retire.we <= ctrl.load_regfile && (ir_q.r_fmt.rd != 5'd0);
			retire.data <= wb_data;
		end
	end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none

module data_ram #(
	parameter int RAM_WORDS = 256
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic exec_en,
	input wire logic [31:0] addr,
	input wire logic [31:0] wdata,
	input wire rv32i_types::rv32i_control_word ctrl,
	output logic [31:0] load_data
);
	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0] mem [RAM_WORDS];
	logic [AW-1:0] idx;
	logic [3:0] be;
	logic [31:0] wlane;
	logic [31:0] rdata_q;
	logic [15:0] half_v;
	logic [7:0] byte_v;

	assign idx = addr[AW+1:2]; // upper bits dropped, address wraps

	// replicate the store data on every lane, the enables pick the bytes
	always_comb begin
		case (ctrl.store_type)
			2'd1: begin
				be = 4'b0001 << addr[1:0];
				wlane = {4{wdata[7:0]}};
			end
			2'd2: begin
				be = 4'b0011 << {addr[1], 1'b0};
				wlane = {2{wdata[15:0]}};
			end
			default: begin
				be = 4'b1111;
				wlane = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (exec_en && ctrl.write) begin
			for (int b = 0; b < 4; b++) begin
				if (be[b]) begin
					mem[idx][8*b +: 8] <= wlane[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata_q <= '0;
		end else if (exec_en && ctrl.read_b) begin
			rdata_q <= mem[idx];
		end
	end

	// addr and ctrl hold steady into writeback
	assign half_v = addr[1] ? rdata_q[31:16] : rdata_q[15:0];
	assign byte_v = rdata_q[8*addr[1:0] +: 8];

	always_comb begin
		case (ctrl.load_type)
			2'd1: load_data = ctrl.load_unsigned ? {24'd0, byte_v} : {{24{byte_v[7]}}, byte_v};
			2'd2: load_data = ctrl.load_unsigned ? {16'd0, half_v} : {{16{half_v[15]}}, half_v};
			default: load_data = rdata_q;
		endcase
	end

endmodule

`default_nettype wire

//--- source/exec_unit.sv
`default_nettype none

module exec_unit (
	input wire rv32i_types::rv32i_instr_u ir,
	input wire rv32i_types::rv32i_control_word ctrl,
	input wire logic [31:0] pc,
	input wire logic [31:0] rs1_data,
	input wire logic [31:0] rs2_data,
	input wire logic [31:0] load_data,
	output logic [31:0] alu_out,
	output logic br_en,
	output logic pc_load,
	output logic [31:0] wb_data
);
	import rv32i_types::*;

	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] b_imm;
	logic [31:0] u_imm;
	logic [31:0] j_imm;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] cmp_b;

	// same word, read through each format view
	assign i_imm = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
	assign s_imm = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
	assign b_imm = {{19{ir.b_fmt.imm12}}, ir.b_fmt.imm12, ir.b_fmt.imm11,
		ir.b_fmt.imm10_5, ir.b_fmt.imm4_1, 1'b0};
	assign u_imm = {ir.u_fmt.imm, 12'h000};
	assign j_imm = {{11{ir.j_fmt.imm20}}, ir.j_fmt.imm20, ir.j_fmt.imm19_12,
		ir.j_fmt.imm11, ir.j_fmt.imm10_1, 1'b0};

	assign alu_a = ctrl.alumux1_sel ? pc : rs1_data;
	assign cmp_b = ctrl.cmpmux_sel ? i_imm : rs2_data;

	always_comb begin
		case (ctrl.alumux2_sel)
			3'd1: alu_b = u_imm;
			3'd2: alu_b = b_imm;
			3'd3: alu_b = s_imm;
			3'd4: alu_b = rs2_data;
			3'd5: alu_b = j_imm;
			default: alu_b = i_imm;
		endcase
	end

	always_comb begin
		case (ctrl.aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_sll: alu_out = alu_a << alu_b[4:0];
			alu_sra: alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
			alu_sub: alu_out = alu_a - alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_srl: alu_out = alu_a >> alu_b[4:0];
			alu_or:  alu_out = alu_a | alu_b;
			default: alu_out = alu_a & alu_b;
		endcase
	end

	always_comb begin
		case (ctrl.cmpop)
			beq:  br_en = (rs1_data == cmp_b);
			bne:  br_en = (rs1_data != cmp_b);
			blt:  br_en = ($signed(rs1_data) < $signed(cmp_b));
			bge:  br_en = ($signed(rs1_data) >= $signed(cmp_b));
			bltu: br_en = (rs1_data < cmp_b);
			bgeu: br_en = (rs1_data >= cmp_b);
			default: br_en = 1'b0; // funct3 010/011 on a branch
		endcase
	end

	assign pc_load = ctrl.pcmux_sel || ((ctrl.opcode == op_br) && br_en);

	always_comb begin
		case (ctrl.regfilemux_sel)
			3'd1: wb_data = {31'd0, br_en}; // slt family
			3'd2: wb_data = u_imm;
			3'd3: wb_data = load_data;
			3'd4: wb_data = pc + 32'd4;
			default: wb_data = alu_out;
		endcase
	end

endmodule

`default_nettype wire

//--- source/pc_unit.sv
`default_nettype none

module pc_unit #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic advance,
	input wire logic pc_load,
	input wire logic [31:0] target,
	output logic [31:0] pc
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (advance) begin
			if (pc_load) begin
				pc <= {target[31:1], 1'b0}; // jalr wants bit 0 cleared
			end else begin
				pc <= pc + 32'd4;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/regfile.sv
`default_nettype none

module regfile (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic we,
	input wire logic [4:0] rd,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic [31:0] wdata,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != 5'd0)) begin // x0 stays zero
			regs[rd] <= wdata;
		end
	end

	assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/rv32i_core.sv
`default_nettype none

module rv32i_core #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000,
	parameter int RAM_WORDS = 256
) (
	input wire logic clk,
	input wire logic rst_n,
	output logic fetch_req,
	output logic [31:0] fetch_pc,
	input wire logic instr_valid,
	input wire rv32i_types::rv32i_instr_u instr,
	output rv32i_types::retire_t retire,
	output logic retire_valid
);
	import rv32i_types::*;

	rv32i_instr_u ir;
	rv32i_control_word ctrl_next;
	rv32i_control_word ctrl;
	logic exec_en;
	logic wb_en;
	logic pc_load;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] alu_out;
	logic [31:0] wb_data;
	logic [31:0] load_data;

	control_rom u_control_rom (
		.opcode (ir.r_fmt.opcode),
		.funct3 (ir.r_fmt.funct3),
		.funct7 (ir.r_fmt.funct7),
		.ctrl   (ctrl_next)
	);

	core_fsm u_core_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.ctrl_next    (ctrl_next),
		.pc           (fetch_pc),
		.wb_data      (wb_data),
		.fetch_req    (fetch_req),
		.ir           (ir),
		.ctrl         (ctrl),
		.exec_en      (exec_en),
		.wb_en        (wb_en),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
		.clk     (clk),
		.rst_n   (rst_n),
		.advance (wb_en),
		.pc_load (pc_load),
		.target  (alu_out),
		.pc      (fetch_pc)
	);

	regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.we       (wb_en && ctrl.load_regfile),
		.rd       (ir.r_fmt.rd),
		.rs1      (ir.r_fmt.rs1),
		.rs2      (ir.r_fmt.rs2),
		.wdata    (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	exec_unit u_exec_unit (
		.ir        (ir),
		.ctrl      (ctrl),
		.pc        (fetch_pc),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.load_data (load_data),
		.alu_out   (alu_out),
		.br_en     (),
		.pc_load   (pc_load),
		.wb_data   (wb_data)
	);

	data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
		.clk       (clk),
		.rst_n     (rst_n),
		.exec_en   (exec_en),
		.addr      (alu_out),
		.wdata     (rs2_data),
		.ctrl      (ctrl),
		.load_data (load_data)
	);

endmodule

`default_nettype wire

//--- source/rv32i_types.sv
`default_nettype none

package rv32i_types;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	// codes line up with the OP funct3 values where they can
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

	typedef enum logic [2:0] {
		add  = 3'b000, // also sub
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101, // srl or sra
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		rv32i_opcode opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		rv32i_opcode opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		rv32i_opcode opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		rv32i_opcode opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // upper 20 bits of the result
		logic [4:0] rd;
		rv32i_opcode opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		rv32i_opcode opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} rv32i_instr_u;

	typedef struct packed {
		rv32i_opcode opcode;
		alu_ops aluop;
		branch_funct3_t cmpop;
		logic load_regfile;
		logic [2:0] regfilemux_sel; // 0 alu, 1 cmp, 2 u_imm, 3 load, 4 pc+4
		logic pcmux_sel;            // unconditional jump
		logic alumux1_sel;          // 0 rs1, 1 pc
		logic [2:0] alumux2_sel;    // 0 i, 1 u, 2 b, 3 s, 4 rs2, 5 j
		logic cmpmux_sel;           // 0 rs2, 1 i_imm
		logic [1:0] load_type;      // 0 word, 1 byte, 2 half
		logic load_unsigned;
		logic [1:0] store_type;     // same coding as load_type
		logic write;
		logic read_b;
	} rv32i_control_word;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0] rd;
		logic we;
		logic [31:0] data;
	} retire_t;

endpackage

`default_nettype wire

//--- verif/clk_gen.sv
`default_nettype none

module clk_gen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

//--- verif/rv32i_core_sva.sv
`default_nettype none

module rv32i_core_sva (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic fetch_req,
	input wire logic instr_valid,
	input wire logic retire_valid,
	input wire logic exec_en,
	input wire logic wb_en
);
	timeunit 1ns;
	timeprecision 1ps;

	logic waiting; // request out and word not yet taken
	logic accept;

	assign accept = instr_valid && (fetch_req || waiting) && !exec_en && !wb_en;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			waiting <= 1'b0;
		end else if (fetch_req) begin
			waiting <= !instr_valid;
		end else if (accept) begin
			waiting <= 1'b0;
		end
	end

	// word taken at edge N, retire_valid rises at edge N+2 and is seen at N+3
	a_retire_latency: assert property (@(posedge clk) disable iff (!rst_n)
		accept |=> !retire_valid ##1 !retire_valid ##1 retire_valid)
		else $error("retire did not follow the accepted word after exactly two cycles");

	a_fetch_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> (!exec_en && !wb_en))
		else $error("fetch request outside the fetch state");

	a_fetch_low_in_reset: assert property (@(posedge clk)
		!rst_n |=> !fetch_req)
		else $error("fetch request during reset");

endmodule

bind rv32i_core rv32i_core_sva u_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.fetch_req    (fetch_req),
	.instr_valid  (instr_valid),
	.retire_valid (retire_valid),
	.exec_en      (exec_en),
	.wb_en        (wb_en)
);

`default_nettype wire

//--- verif/tb_rv32i_core.sv
`default_nettype none

module tb_rv32i_core;
	timeunit 1ns;
	timeprecision 1ps;
	import rv32i_types::*;

	localparam int N_INSTR = 400;
	localparam int PROLOGUE = 16; // sw x0 over the 64 bytes that loads use
	localparam int TIMEOUT = N_INSTR * (3 + 3) + 100;
	localparam logic [15:0] SEED = 16'd49885;

	logic clk;
	logic rst_n;
	logic fetch_req;
	logic [31:0] fetch_pc;
	logic instr_valid;
	rv32i_instr_u instr;
	retire_t retire;
	logic retire_valid;

	logic [15:0] lfsr;
	logic [31:0] prog [N_INSTR];
	logic [31:0] mregs [32];
	logic [7:0] mbytes [1024];
	logic [31:0] mpc;
	retire_t exp_q[$];
	int issue_q[$];
	int cyc;
	int issued;
	int retired;
	int errors;

	clk_gen u_clk_gen (.clk(clk));

	rv32i_core #(.RESET_PC(32'h0), .RAM_WORDS(256)) DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_req    (fetch_req),
		.fetch_pc     (fetch_pc),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire       (retire),
		.retire_valid (retire_valid)
	);

	function automatic logic [19:0] take_bits(input int n);
		logic [19:0] v;
		logic b;
		v = '0;
		for (int k = 0; k < n; k++) begin
			b = lfsr[0]; // galois step, one per bit
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ 16'hB400;
			v = {v[18:0], b};
		end
		return v;
	endfunction

	function automatic logic [31:0] gen_instr(input int i);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic [31:0] off;
		logic [3:0] kind;
		logic [2:0] lsel [5];
		logic [2:0] bsel [6];
		lsel = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		bsel = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		if (i < PROLOGUE) begin
			off = i * 4;
			return {off[11:5], 5'd0, 5'd0, 3'b010, off[4:0], 7'b0100011};
		end
		kind = 4'(take_bits(4));
		rd = 5'(take_bits(3));
		rs1 = 5'(take_bits(3));
		rs2 = 5'(take_bits(3));
		f3 = 3'(take_bits(3));
		case (kind)
			4'd0, 4'd1, 4'd2: begin
				imm = ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1)) ? 12'h400 : 12'h000;
				return {imm[11:5], rs2, rs1, f3, rd, 7'b0110011};
			end
			4'd3, 4'd4, 4'd5, 4'd15: begin
				imm = 12'(take_bits(12));
				if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
				if (f3 == 3'd5) imm = {1'b0, imm[10], 5'd0, imm[4:0]}; // srli or srai
				return {imm, rs1, f3, rd, 7'b0010011};
			end
			4'd6: return {take_bits(20), rd, 7'b0110111};
			4'd7: return {take_bits(20), rd, 7'b0010111};
			4'd8: begin
				f3 = lsel[take_bits(3) % 5];
				imm = 12'(take_bits(6));
				if (f3[1:0] == 2'd2) imm[1:0] = 2'b00;
				if (f3[1:0] == 2'd1) imm[0] = 1'b0;
				return {imm, 5'd0, f3, rd, 7'b0000011};
			end
			4'd9, 4'd10: begin
				f3 = 3'(take_bits(2) % 3);
				imm = 12'(take_bits(6));
				if (f3 == 3'd2) imm[1:0] = 2'b00;
				if (f3 == 3'd1) imm[0] = 1'b0;
				return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
			end
			4'd11: begin
				f3 = bsel[take_bits(3) % 6];
				off = (1 + take_bits(3)) * 4; // forward only
				return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
			end
			4'd12: begin
				off = (1 + take_bits(3)) * 4;
				return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
			end
			4'd13: begin
				off = ((i + 1 + take_bits(3)) % N_INSTR) * 4 + take_bits(1); // bit 0 is dropped
				return {off[11:0], 5'd0, 3'b000, rd, 7'b1100111};
			end
			default: return take_bits(1) ? 32'h0000_000f : 32'h0000_0073; // fence, ecall
		endcase
	endfunction

	function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y, input logic alt);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'd0, $signed(x) < $signed(y)};
			3'd3: return {31'd0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			3'd7: return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] addr);
		logic [31:0] w;
		for (int k = 0; k < 4; k++) begin
			w[8*k +: 8] = mbytes[(addr + k) & 32'd1023];
		end
		case (f3)
			3'd0: return {{24{w[7]}}, w[7:0]};
			3'd1: return {{16{w[15]}}, w[15:0]};
			3'd4: return {24'd0, w[7:0]};
			3'd5: return {16'd0, w[15:0]};
			default: return w;
		endcase
	endfunction

	// architectural model of one instruction at mpc
	function automatic retire_t ref_step(input rv32i_instr_u iw);
		retire_t r;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] npc;
		logic [31:0] addr;
		logic wr;
		logic [2:0] f3;
		w = iw;
		f3 = iw.r_fmt.funct3;
		a = mregs[iw.r_fmt.rs1];
		b = mregs[iw.r_fmt.rs2];
		npc = mpc + 32'd4;
		res = '0;
		wr = 1'b0;
		case (w[6:0])
			7'b0110111: {wr, res} = {1'b1, w[31:12], 12'h000};
			7'b0010111: {wr, res} = {1'b1, mpc + {w[31:12], 12'h000}};
			7'b1101111: begin
				{wr, res} = {1'b1, mpc + 32'd4};
				npc = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			7'b1100111: begin
				{wr, res} = {1'b1, mpc + 32'd4};
				npc = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
			end
			7'b1100011: begin
				if (branch_taken(f3, a, b))
					npc = mpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			7'b0000011: begin
				addr = a + {{20{w[31]}}, w[31:20]};
				{wr, res} = {1'b1, load_value(f3, addr)};
			end
			7'b0100011: begin
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				for (int k = 0; k < (f3 == 3'd0 ? 1 : (f3 == 3'd1 ? 2 : 4)); k++) begin
					mbytes[(addr + k) & 32'd1023] = b[8*k +: 8];
				end
			end
			7'b0010011: begin
				res = alu_calc(f3, a, {{20{w[31]}}, w[31:20]}, (f3 == 3'd5) && w[30]);
				wr = 1'b1;
			end
			7'b0110011: {wr, res} = {1'b1, alu_calc(f3, a, b, w[30])};
			default: ; // unknown opcodes retire with no effect
		endcase
		r.pc = mpc;
		r.rd = w[11:7];
		r.we = wr && (w[11:7] != 5'd0);
		r.data = res;
		if (r.we) mregs[w[11:7]] = res;
		mpc = npc;
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		errors++;
		$display("mismatch %s expected %h actual %h", name, exp_v, act_v);
		$display("test failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("timeout after %0d cycles with %0d retired", cyc, retired);
			$display("test failed");
			$fatal(1);
		end
	end

	// instruction server
	initial begin
		int gap;
		int idx;
		forever begin
			@(negedge clk);
			if (rst_n && fetch_req && issued < N_INSTR) begin
				assert (fetch_pc == mpc)
					else report_mismatch($sformatf("fetch_pc@%0d", issued), mpc, fetch_pc);
				gap = take_bits(2);
				repeat (gap) @(negedge clk);
				idx = (fetch_pc >> 2) % N_INSTR;
				instr = prog[idx];
				instr_valid = 1'b1;
				exp_q.push_back(ref_step(prog[idx]));
				issue_q.push_back(cyc);
				issued++;
				@(negedge clk);
				instr_valid = 1'b0;
			end
		end
	end

	// comparator
	always @(negedge clk) begin
		retire_t e;
		int t;
		if (rst_n && retire_valid) begin
			assert (exp_q.size() > 0)
				else begin
					$display("retire seen with no instruction outstanding");
					$display("test failed");
					$fatal(1);
				end
			e = exp_q.pop_front();
			t = issue_q.pop_front();
			assert (cyc - t == 3)
				else report_mismatch($sformatf("latency@%0d", retired), 32'(t + 3), cyc);
			assert (retire.pc == e.pc)
				else report_mismatch($sformatf("pc@%0d", retired), e.pc, retire.pc);
			assert (retire.rd == e.rd)
				else report_mismatch($sformatf("rd@%0d", retired), 32'(e.rd), 32'(retire.rd));
			assert (retire.we == e.we)
				else report_mismatch($sformatf("we@%0d", retired), 32'(e.we), 32'(retire.we));
			assert (!e.we || retire.data == e.data)
				else report_mismatch($sformatf("data@%0d", retired), e.data, retire.data);
			retired++;
		end
	end

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		cyc = 0;
		issued = 0;
		retired = 0;
		errors = 0;
		mpc = 32'h0;
		lfsr = SEED;
		for (int i = 0; i < 32; i++) mregs[i] = '0;
		for (int i = 0; i < 1024; i++) mbytes[i] = 8'h00;
		for (int i = 0; i < N_INSTR; i++) prog[i] = gen_instr(i);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		wait (retired == N_INSTR);
		@(negedge clk);
		if (errors == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
